//--- sim.f
+incdir+rtl
rtl/tsc_pkg.sv
rtl/alu.sv
rtl/register_file.sv
rtl/control_unit.sv
rtl/datapath.sv
rtl/cpu.sv
tests/clock_gen.sv
tests/cpu_checker.sv
tests/tb_cpu.sv

//--- Bender.yml
package:
  name: tsc_cpu

export_include_dirs:
  - rtl

sources:
  - rtl/tsc_pkg.sv
  - rtl/alu.sv
  - rtl/register_file.sv
  - rtl/control_unit.sv
  - rtl/datapath.sv
  - rtl/cpu.sv
  - target: test
    files:
      - tests/clock_gen.sv
      - tests/cpu_checker.sv
      - tests/tb_cpu.sv

//--- tests/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "tsc_cfg.svh"

module tb_cpu;
  import tsc_pkg::*;

  localparam int NUM_TESTS   = 26;
  localparam int PROG_WORDS  = 73;
  localparam int MAX_CYCLES  = PROG_WORDS * 5 + 200;
  localparam int HOLD_CYCLES = 20;

  localparam logic [7:0] IMM_LHI   = 8'h12;
  localparam logic [7:0] IMM_ADI   = 8'h34;
  localparam logic [7:0] IMM_NEG   = 8'hf0;
  localparam logic [7:0] IMM_ORI   = 8'hc0;
  localparam logic [7:0] DATA_ADDR = 8'h70;

  // label addresses in the program image
  localparam int JMP_DEST = 57;
  localparam int JAL_ADDR = 59;
  localparam int SUB_ADDR = 62;
  localparam int JRL_PREP = 66;
  localparam int JRL_ADDR = 67;
  localparam int JRL_DEST = 70;

  logic  clk;
  logic  reset;
  word_t mem_address;
  word_t mem_wdata;
  word_t mem_rdata;
  word_t output_port;
  logic  mem_read;
  logic  mem_write;
  logic  wwd;
  logic  halted;

  word_t mem [256];
  word_t store_addr;
  word_t store_data;
  int    store_count = 0;

  string test_name [NUM_TESTS];
  word_t test_expect [NUM_TESTS];
  int    num_loaded = 0;

  int cycles     = 0;
  int wwd_count  = 0;
  int pass_count = 0;
  int fail_count = 0;

  clock_gen i_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  cpu i_cpu (
    .clk         (clk),
    .reset       (reset),
    .mem_address (mem_address),
    .mem_read    (mem_read),
    .mem_write   (mem_write),
    .mem_wdata   (mem_wdata),
    .mem_rdata   (mem_rdata),
    .output_port (output_port),
    .wwd         (wwd),
    .halted      (halted)
  );

  bind cpu cpu_checker i_cpu_checker (
    .clk       (clk),
    .reset     (reset),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .wwd       (wwd),
    .halted    (halted)
  );

  // memory drives read data only while mem_read is high
  assign mem_rdata = mem_read ? mem[mem_address[7:0]] : 'x;

  always @(posedge clk) begin
    if (mem_write) begin
      mem[mem_address[7:0]] <= mem_wdata;
      store_addr            <= mem_address;
      store_data            <= mem_wdata;
      store_count           <= store_count + 1;
    end
  end

  always @(posedge clk) begin
    if (!reset && wwd) begin
      wwd_count <= wwd_count + 1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the processor never halted", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  function automatic word_t enc_r(input logic [1:0] rs, input logic [1:0] rt,
                                  input logic [1:0] rd, input logic [5:0] func);
    return {`TSC_OP_RTYPE, rs, rt, rd, func};
  endfunction

  function automatic word_t enc_i(input logic [3:0] op, input logic [1:0] rs,
                                  input logic [1:0] rt, input logic [7:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t enc_j(input logic [3:0] op, input logic [11:0] target);
    return {op, target};
  endfunction

  function automatic word_t sext8(input logic [7:0] v);
    return {{8{v[7]}}, v};
  endfunction

  task automatic load_program();
    for (int a = 0; a < 256; a++) begin
      // opcode 11 is unused so a stray fetch halts
      mem[a] <= {4'hb, 4'h0, a[7:0]};
    end
    mem[0]  <= enc_i(`TSC_OP_LHI, 2'd0, 2'd1, IMM_LHI);
    mem[1]  <= enc_r(2'd1, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[2]  <= enc_i(`TSC_OP_ADI, 2'd1, 2'd1, IMM_ADI);
    mem[3]  <= enc_r(2'd1, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[4]  <= enc_i(`TSC_OP_ADI, 2'd0, 2'd2, IMM_NEG);
    mem[5]  <= enc_r(2'd2, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[6]  <= enc_i(`TSC_OP_ORI, 2'd1, 2'd3, IMM_ORI);
    mem[7]  <= enc_r(2'd3, 2'd0, 2'd0, `TSC_FUNC_WWD);
    // r-type on r1, r2 into r3
    mem[8]  <= enc_r(2'd1, 2'd2, 2'd3, `TSC_FUNC_ADD);
    mem[9]  <= enc_r(2'd3, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[10] <= enc_r(2'd1, 2'd2, 2'd3, `TSC_FUNC_SUB);
    mem[11] <= enc_r(2'd3, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[12] <= enc_r(2'd1, 2'd2, 2'd3, `TSC_FUNC_AND);
    mem[13] <= enc_r(2'd3, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[14] <= enc_r(2'd1, 2'd2, 2'd3, `TSC_FUNC_ORR);
    mem[15] <= enc_r(2'd3, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[16] <= enc_r(2'd1, 2'd0, 2'd3, `TSC_FUNC_NOT);
    mem[17] <= enc_r(2'd3, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[18] <= enc_r(2'd1, 2'd0, 2'd3, `TSC_FUNC_TCP);
    mem[19] <= enc_r(2'd3, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[20] <= enc_r(2'd1, 2'd0, 2'd3, `TSC_FUNC_SHL);
    mem[21] <= enc_r(2'd3, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[22] <= enc_r(2'd2, 2'd0, 2'd3, `TSC_FUNC_SHR);
    mem[23] <= enc_r(2'd3, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[24] <= enc_i(`TSC_OP_SWD, 2'd0, 2'd1, DATA_ADDR);
    mem[25] <= enc_i(`TSC_OP_LWD, 2'd0, 2'd3, DATA_ADDR);
    mem[26] <= enc_r(2'd3, 2'd0, 2'd0, `TSC_FUNC_WWD);
    // r0 counts the branch check points
    mem[27] <= enc_i(`TSC_OP_BEQ, 2'd1, 2'd3, 8'd1);
    mem[28] <= enc_r(2'd2, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[29] <= enc_i(`TSC_OP_ADI, 2'd0, 2'd0, 8'd1);
    mem[30] <= enc_r(2'd0, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[31] <= enc_i(`TSC_OP_BEQ, 2'd1, 2'd2, 8'd1);
    mem[32] <= enc_i(`TSC_OP_ADI, 2'd0, 2'd0, 8'd1);
    mem[33] <= enc_r(2'd0, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[34] <= enc_i(`TSC_OP_BNE, 2'd1, 2'd2, 8'd1);
    mem[35] <= enc_r(2'd2, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[36] <= enc_i(`TSC_OP_ADI, 2'd0, 2'd0, 8'd1);
    mem[37] <= enc_r(2'd0, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[38] <= enc_i(`TSC_OP_BNE, 2'd1, 2'd3, 8'd1);
    mem[39] <= enc_i(`TSC_OP_ADI, 2'd0, 2'd0, 8'd1);
    mem[40] <= enc_r(2'd0, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[41] <= enc_i(`TSC_OP_BGZ, 2'd1, 2'd0, 8'd1);
    mem[42] <= enc_r(2'd2, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[43] <= enc_i(`TSC_OP_ADI, 2'd0, 2'd0, 8'd1);
    mem[44] <= enc_r(2'd0, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[45] <= enc_i(`TSC_OP_BGZ, 2'd2, 2'd0, 8'd1);
    mem[46] <= enc_i(`TSC_OP_ADI, 2'd0, 2'd0, 8'd1);
    mem[47] <= enc_r(2'd0, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[48] <= enc_i(`TSC_OP_BLZ, 2'd2, 2'd0, 8'd1);
    mem[49] <= enc_r(2'd1, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[50] <= enc_i(`TSC_OP_ADI, 2'd0, 2'd0, 8'd1);
    mem[51] <= enc_r(2'd0, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[52] <= enc_i(`TSC_OP_BLZ, 2'd1, 2'd0, 8'd1);
    mem[53] <= enc_i(`TSC_OP_ADI, 2'd0, 2'd0, 8'd1);
    mem[54] <= enc_r(2'd0, 2'd0, 2'd0, `TSC_FUNC_WWD);
    // jumps
    mem[55] <= enc_j(`TSC_OP_JMP, 12'(JMP_DEST));
    mem[56] <= enc_r(2'd2, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[57] <= enc_i(`TSC_OP_ADI, 2'd0, 2'd0, 8'd1);
    mem[58] <= enc_r(2'd0, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[59] <= enc_j(`TSC_OP_JAL, 12'(SUB_ADDR));
    mem[60] <= enc_r(2'd2, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[61] <= enc_j(`TSC_OP_JMP, 12'(JRL_PREP));
    mem[62] <= enc_i(`TSC_OP_ADI, 2'd0, 2'd0, 8'd1);
    mem[63] <= enc_r(2'd0, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[64] <= enc_r(2'd2, 2'd0, 2'd0, `TSC_FUNC_JPR);
    mem[65] <= enc_r(2'd1, 2'd0, 2'd0, `TSC_FUNC_WWD);
    // r0 holds 10 here
    mem[66] <= enc_i(`TSC_OP_ADI, 2'd0, 2'd1, 8'(JRL_DEST - 10));
    mem[67] <= enc_r(2'd1, 2'd0, 2'd0, `TSC_FUNC_JRL);
    mem[68] <= enc_r(2'd2, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[69] <= enc_r(2'd0, 2'd0, 2'd0, `TSC_FUNC_HLT);
    mem[70] <= enc_i(`TSC_OP_ADI, 2'd0, 2'd0, 8'd1);
    mem[71] <= enc_r(2'd0, 2'd0, 2'd0, `TSC_FUNC_WWD);
    mem[72] <= enc_r(2'd2, 2'd0, 2'd0, `TSC_FUNC_JPR);
  endtask

  task automatic add_test(input string name, input word_t value);
    test_name[num_loaded]   = name;
    test_expect[num_loaded] = value;
    num_loaded++;
  endtask

  task automatic load_tests();
    word_t lhi_val;
    word_t r1_val;
    word_t r2_val;
    lhi_val = {IMM_LHI, 8'h00};
    r1_val  = lhi_val + sext8(IMM_ADI);
    r2_val  = sext8(IMM_NEG);
    add_test("lhi", lhi_val);
    add_test("adi_pos", r1_val);
    add_test("adi_neg", r2_val);
    add_test("ori", r1_val | {8'h00, IMM_ORI});
    add_test("add", r1_val + r2_val);
    add_test("sub", r1_val - r2_val);
    add_test("and", r1_val & r2_val);
    add_test("orr", r1_val | r2_val);
    add_test("not", ~r1_val);
    add_test("tcp", word_t'(0) - r1_val);
    add_test("shl", {r1_val[14:0], 1'b0});
    add_test("shr", {r2_val[15], r2_val[15:1]});
    add_test("load_store", r1_val);
    add_test("beq_taken", word_t'(1));
    add_test("beq_not_taken", word_t'(2));
    add_test("bne_taken", word_t'(3));
    add_test("bne_not_taken", word_t'(4));
    add_test("bgz_taken", word_t'(5));
    add_test("bgz_not_taken", word_t'(6));
    add_test("blz_taken", word_t'(7));
    add_test("blz_not_taken", word_t'(8));
    add_test("jmp", word_t'(9));
    add_test("jal_target", word_t'(10));
    add_test("jal_link", word_t'(JAL_ADDR + 1));
    add_test("jrl_target", word_t'(11));
    add_test("jrl_link", word_t'(JRL_ADDR + 1));
  endtask

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (expected === actual) begin
      pass_count++;
    end else begin
      fail_count++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // waits for the next wwd pulse or for halt
  task automatic wait_for_output(output logic seen, output word_t value);
    seen  = 1'b0;
    value = '0;
    do begin
      @(negedge clk);
    end while (wwd !== 1'b1 && halted !== 1'b1);
    if (wwd === 1'b1) begin
      seen  = 1'b1;
      value = output_port;
    end
  endtask

  initial begin
    int    fails_before;
    int    fail_total;
    logic  seen;
    logic  held;
    word_t got;
    load_program();
    load_tests();
    wait (reset === 1'b0);

    for (int i = 0; i < NUM_TESTS; i++) begin
      fails_before = fail_count;
      wait_for_output(seen, got);
      if (seen) begin
        check_value(test_name[i], test_expect[i], got);
      end else begin
        fail_count++;
        $display("test %s: the processor halted before this output appeared", test_name[i]);
      end
      $display("test %-14s %s", test_name[i], (fail_count == fails_before) ? "ok" : "mismatch");
    end

    fails_before = fail_count;
    check_value("store_count", word_t'(1), word_t'(store_count));
    check_value("store_addr", {8'h00, DATA_ADDR}, store_addr);
    check_value("store_data", test_expect[1], store_data);
    $display("test %-14s %s", "store_port", (fail_count == fails_before) ? "ok" : "mismatch");

    while (halted !== 1'b1) begin
      @(negedge clk);
    end
    held = 1'b1;
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      if (halted !== 1'b1) begin
        held = 1'b0;
      end
    end
    fails_before = fail_count;
    check_value("halt_held", word_t'(1), word_t'(held));
    check_value("halt_quiet", word_t'(NUM_TESTS), word_t'(wwd_count));
    $display("test %-14s %s", "halt", (fail_count == fails_before) ? "ok" : "mismatch");

    fail_total = fail_count + i_cpu.i_cpu_checker.assert_errors;
    $display("checks passed %0d, failed %0d", pass_count, fail_total);
    if (fail_total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/cpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
  input logic clk,
  input logic reset,
  input logic mem_read,
  input logic mem_write,
  input logic wwd,
  input logic halted
);

  int assert_errors = 0;

  // one memory strobe at a time
  no_read_and_write: assert property (@(posedge clk) disable iff (reset)
      !(mem_read && mem_write))
    else begin
      assert_errors++;
      $error("mem_read and mem_write high in the same cycle");
    end

  // hlt only leaves through reset
  halt_sticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
    else begin
      assert_errors++;
      $error("halted fell without reset");
    end

  wwd_one_cycle: assert property (@(posedge clk) disable iff (reset) wwd |=> !wwd)
    else begin
      assert_errors++;
      $error("wwd held for more than one cycle");
    end

endmodule

`default_nettype wire

//--- tests/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

//--- rtl/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu (
  input  logic           clk,
  input  logic           reset,
  output tsc_pkg::word_t mem_address,
  output logic           mem_read,
  output logic           mem_write,
  output tsc_pkg::word_t mem_wdata,
  input  tsc_pkg::word_t mem_rdata,
  output tsc_pkg::word_t output_port,
  output logic           wwd,
  output logic           halted
);
  import tsc_pkg::*;

  ctrl_t   ctrl;
  opcode_t opcode;
  func_t   func;

  control_unit i_control_unit (
    .clk    (clk),
    .reset  (reset),
    .opcode (opcode),
    .func   (func),
    .ctrl   (ctrl)
  );

  datapath i_datapath (
    .clk         (clk),
    .reset       (reset),
    .ctrl        (ctrl),
    .opcode      (opcode),
    .func        (func),
    .mem_address (mem_address),
    .mem_wdata   (mem_wdata),
    .mem_rdata   (mem_rdata),
    .mem_read    (mem_read),
    .mem_write   (mem_write),
    .output_port (output_port)
  );

  assign wwd    = ctrl.wwd;
  assign halted = ctrl.halt;

endmodule

`default_nettype wire

//--- rtl/datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "tsc_cfg.svh"

module datapath (
  input  logic             clk,
  input  logic             reset,
  input  tsc_pkg::ctrl_t   ctrl,
  output tsc_pkg::opcode_t opcode,
  output tsc_pkg::func_t   func,
  output tsc_pkg::word_t   mem_address,
  output tsc_pkg::word_t   mem_wdata,
  input  tsc_pkg::word_t   mem_rdata,
  output logic             mem_read,
  output logic             mem_write,
  output tsc_pkg::word_t   output_port
);
  import tsc_pkg::*;

  word_t    pc, ir, a_q, b_q, alu_out_q, mdr;
  logic     cond_q;
  word_t    rs_data, rt_data, imm_ext, jump_target;
  word_t    alu_a, alu_b, alu_result, pc_next, wb_data;
  reg_idx_t rs, rt, rd, waddr;
  alu_op_t  alu_op;
  logic     alu_cond;

  assign opcode = ir[15:12];
  assign func   = ir[5:0];
  assign rs     = ir[11:10];
  assign rt     = ir[9:8];
  assign rd     = ir[7:6];

  // ori zero-extends, everything else sign-extends
  assign imm_ext     = (opcode == `TSC_OP_ORI) ? {8'h00, ir[7:0]} : {{8{ir[7]}}, ir[7:0]};
  assign jump_target = {pc[15:12], ir[11:0]};

  always_comb begin
    case (ctrl.alu_src_a)
      2'b00:   alu_a = pc;
      2'b01:   alu_a = a_q;
      default: alu_a = '0;
    endcase
    case (ctrl.alu_src_b)
      2'b00:   alu_b = b_q;
      2'b01:   alu_b = word_t'(1);
      2'b10:   alu_b = imm_ext;
      default: alu_b = '0;
    endcase
  end

  always_comb begin
    alu_op = alu_add;
    if (ctrl.alu_use_func) begin
      case (opcode)
        `TSC_OP_RTYPE: begin
          case (func)
            `TSC_FUNC_SUB: alu_op = alu_sub;
            `TSC_FUNC_AND: alu_op = alu_and;
            `TSC_FUNC_ORR: alu_op = alu_or;
            `TSC_FUNC_NOT: alu_op = alu_not;
            `TSC_FUNC_TCP: alu_op = alu_tcp;
            `TSC_FUNC_SHL: alu_op = alu_shl;
            `TSC_FUNC_SHR: alu_op = alu_shr;
            default:       alu_op = alu_add;
          endcase
        end
        `TSC_OP_ORI: alu_op = alu_ori;
        `TSC_OP_LHI: alu_op = alu_lhi;
        `TSC_OP_BNE: alu_op = alu_bne;
        `TSC_OP_BEQ: alu_op = alu_beq;
        `TSC_OP_BGZ: alu_op = alu_bgz;
        `TSC_OP_BLZ: alu_op = alu_blz;
        default:     alu_op = alu_add;
      endcase
    end
  end

  register_file i_register_file (
    .clk      (clk),
    .reset    (reset),
    .rs       (rs),
    .rt       (rt),
    .rd_data1 (rs_data),
    .rd_data2 (rt_data),
    .we       (ctrl.reg_write != 2'b00),
    .waddr    (waddr),
    .wdata    (wb_data)
  );

  alu i_alu (
    .a      (alu_a),
    .b      (alu_b),
    .op     (alu_op),
    .result (alu_result),
    .cond   (alu_cond)
  );

  assign pc_next = ctrl.pc_src ? jump_target : alu_result;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (ctrl.pc_write || (ctrl.pc_write_cond && cond_q)) begin
      pc <= pc_next;
    end
  end

  // latches between states, loaded every cycle
  always_ff @(posedge clk) begin
    if (ctrl.ir_write) begin
      ir <= mem_rdata;
    end
    a_q       <= rs_data;
    b_q       <= rt_data;
    alu_out_q <= alu_result;
    mdr       <= mem_rdata;
    cond_q    <= alu_cond;
  end

  always_comb begin
    case (ctrl.reg_write)
      2'b01:   waddr = rd;
      2'b10:   waddr = rt;
      default: waddr = reg_idx_t'(2);
    endcase
  end

  assign wb_data = ctrl.pc_to_reg ? pc : (ctrl.mem_to_reg ? mdr : alu_out_q);

  assign mem_address = ctrl.i_or_d ? alu_out_q : pc;
  assign mem_wdata   = b_q;
  assign mem_read    = ctrl.mem_read;
  assign mem_write   = ctrl.mem_write;
  assign output_port = a_q;

endmodule

`default_nettype wire

//--- rtl/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "tsc_cfg.svh"

module control_unit (
  input  logic             clk,
  input  logic             reset,
  input  tsc_pkg::opcode_t opcode,
  input  tsc_pkg::func_t   func,
  output tsc_pkg::ctrl_t   ctrl
);
  import tsc_pkg::*;

  cu_state_t state;
  cu_state_t state_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_if;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = st_if;
    case (state)
      st_if: state_next = st_id;
      st_id: begin
        case (opcode)
          `TSC_OP_RTYPE: begin
            case (func)
              `TSC_FUNC_JPR: state_next = st_jpr;
              `TSC_FUNC_JRL: state_next = st_jrl;
              `TSC_FUNC_WWD: state_next = st_wwd;
              `TSC_FUNC_HLT: state_next = st_hlt;
              default:       state_next = st_r_ex;
            endcase
          end
          `TSC_OP_ADI, `TSC_OP_ORI, `TSC_OP_LHI: state_next = st_i_ex;
          `TSC_OP_LWD, `TSC_OP_SWD: state_next = st_mem_ex;
          `TSC_OP_BNE, `TSC_OP_BEQ, `TSC_OP_BGZ, `TSC_OP_BLZ: state_next = st_b_check;
          `TSC_OP_JAL: state_next = st_jal;
          `TSC_OP_JMP: state_next = st_jmp;
          // unknown opcode stops the machine
          default: state_next = st_hlt;
        endcase
      end
      st_r_ex:   state_next = st_r_wb;
      st_i_ex:   state_next = st_i_wb;
      st_mem_ex: state_next = (opcode == `TSC_OP_LWD) ? st_ld_mem : st_sd_mem;
      st_ld_mem: state_next = st_ld_wb;
      st_b_check: state_next = st_b_complete;
      // link first, then the jump itself
      st_jal: state_next = st_jmp;
      st_jrl: state_next = st_jpr;
      st_hlt: state_next = st_hlt;
      default: state_next = st_if;
    endcase
  end

  always_comb begin
    ctrl = '0;
    case (state)
      st_if: begin
        ctrl.mem_read  = 1'b1;
        ctrl.ir_write  = 1'b1;
        ctrl.pc_write  = 1'b1;
        ctrl.alu_src_b = 2'b01;
      end
      st_r_ex: begin
        ctrl.alu_src_a    = 2'b01;
        ctrl.alu_use_func = 1'b1;
      end
      st_r_wb: ctrl.reg_write = 2'b01;
      st_i_ex: begin
        ctrl.alu_src_a    = 2'b01;
        ctrl.alu_src_b    = 2'b10;
        ctrl.alu_use_func = 1'b1;
      end
      st_i_wb: ctrl.reg_write = 2'b10;
      st_mem_ex: begin
        // effective address rs + imm
        ctrl.alu_src_a = 2'b01;
        ctrl.alu_src_b = 2'b10;
      end
      st_ld_mem: begin
        ctrl.mem_read = 1'b1;
        ctrl.i_or_d   = 1'b1;
      end
      st_ld_wb: begin
        ctrl.reg_write  = 2'b10;
        ctrl.mem_to_reg = 1'b1;
      end
      st_sd_mem: begin
        ctrl.mem_write = 1'b1;
        ctrl.i_or_d    = 1'b1;
      end
      st_b_check: begin
        ctrl.alu_src_a    = 2'b01;
        ctrl.alu_use_func = 1'b1;
      end
      st_b_complete: begin
        // pc already holds pc+1
        ctrl.alu_src_b     = 2'b10;
        ctrl.pc_write_cond = 1'b1;
      end
      st_jal, st_jrl: begin
        ctrl.pc_to_reg = 1'b1;
        ctrl.reg_write = 2'b11;
      end
      st_jmp: begin
        ctrl.pc_write = 1'b1;
        ctrl.pc_src   = 1'b1;
      end
      st_jpr: begin
        ctrl.alu_src_a = 2'b01;
        ctrl.alu_src_b = 2'b11;
        ctrl.pc_write  = 1'b1;
      end
      st_wwd: ctrl.wwd = 1'b1;
      st_hlt: ctrl.halt = 1'b1;
      default: ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "tsc_cfg.svh"

module register_file (
  input  logic              clk,
  input  logic              reset,
  input  tsc_pkg::reg_idx_t rs,
  input  tsc_pkg::reg_idx_t rt,
  output tsc_pkg::word_t    rd_data1,
  output tsc_pkg::word_t    rd_data2,
  input  logic              we,
  input  tsc_pkg::reg_idx_t waddr,
  input  tsc_pkg::word_t    wdata
);
  import tsc_pkg::*;

  word_t regs [`TSC_NUM_REGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `TSC_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  assign rd_data1 = regs[rs];
  assign rd_data2 = regs[rt];

endmodule

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "tsc_cfg.svh"

module alu (
  input  tsc_pkg::word_t   a,
  input  tsc_pkg::word_t   b,
  input  tsc_pkg::alu_op_t op,
  output tsc_pkg::word_t   result,
  output logic             cond
);
  import tsc_pkg::*;

  always_comb begin
    result = '0;
    cond   = 1'b0;
    case (op)
      alu_add:         result = a + b;
      alu_sub:         result = a - b;
      alu_and:         result = a & b;
      alu_or, alu_ori: result = a | b;
      alu_not:         result = ~a;
      alu_tcp:         result = ~a + word_t'(1);
      alu_shl:         result = a << 1;
      alu_shr:         result = word_t'($signed(a) >>> 1);
      // low byte of imm into the upper half
      alu_lhi:         result = b << (`TSC_WORD_WIDTH / 2);
      alu_bne:         cond = (a != b);
      alu_beq:         cond = (a == b);
      // bgz and blz look at rs only
      alu_bgz:         cond = ($signed(a) > 0);
      alu_blz:         cond = ($signed(a) < 0);
      default:         result = a + b;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/tsc_pkg.sv
`default_nettype none

`include "tsc_cfg.svh"

package tsc_pkg;

  typedef logic [`TSC_WORD_WIDTH-1:0]       word_t;
  typedef logic [3:0]                       opcode_t;
  typedef logic [5:0]                       func_t;
  typedef logic [$clog2(`TSC_NUM_REGS)-1:0] reg_idx_t;

  typedef enum logic [4:0] {
    st_if, st_id,
    st_r_ex, st_r_wb,
    st_i_ex, st_i_wb,
    st_mem_ex, st_ld_mem, st_ld_wb, st_sd_mem,
    st_b_check, st_b_complete,
    st_jal, st_jmp, st_jrl, st_jpr,
    st_wwd, st_hlt
  } cu_state_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or,
    alu_not, alu_tcp, alu_shl, alu_shr,
    alu_lhi, alu_ori,
    alu_bne, alu_beq, alu_bgz, alu_blz
  } alu_op_t;

  typedef struct packed {
    logic       pc_write;
    logic       pc_write_cond;
    logic       pc_src;         // 0 alu result, 1 jump target
    logic       i_or_d;         // 0 pc, 1 aluout as address
    logic       mem_read;
    logic       mem_write;
    logic       mem_to_reg;
    logic       ir_write;
    logic [1:0] reg_write;      // 00 none, 01 rd, 10 rt, 11 link reg 2
    logic       pc_to_reg;
    logic [1:0] alu_src_a;      // 00 pc, 01 a latch
    logic [1:0] alu_src_b;      // 00 b latch, 01 one, 10 imm, 11 zero
    logic       alu_use_func;
    logic       wwd;
    logic       halt;
  } ctrl_t;

endpackage

`default_nettype wire

//--- rtl/tsc_cfg.svh
`ifndef TSC_CFG_SVH
`define TSC_CFG_SVH

`define TSC_WORD_WIDTH 16
`define TSC_NUM_REGS   4

// opcodes, bits 15:12
`define TSC_OP_BNE   4'd0
`define TSC_OP_BEQ   4'd1
`define TSC_OP_BGZ   4'd2
`define TSC_OP_BLZ   4'd3
`define TSC_OP_ADI   4'd4
`define TSC_OP_ORI   4'd5
`define TSC_OP_LHI   4'd6
`define TSC_OP_LWD   4'd7
`define TSC_OP_SWD   4'd8
`define TSC_OP_JMP   4'd9
`define TSC_OP_JAL   4'd10
`define TSC_OP_RTYPE 4'd15

// func field of R-type, bits 5:0
`define TSC_FUNC_ADD 6'd0
`define TSC_FUNC_SUB 6'd1
`define TSC_FUNC_AND 6'd2
`define TSC_FUNC_ORR 6'd3
`define TSC_FUNC_NOT 6'd4
`define TSC_FUNC_TCP 6'd5
`define TSC_FUNC_SHL 6'd6
`define TSC_FUNC_SHR 6'd7
`define TSC_FUNC_JPR 6'd25
`define TSC_FUNC_JRL 6'd26
`define TSC_FUNC_WWD 6'd28
`define TSC_FUNC_HLT 6'd29

`endif
